// File: Bender.yml
package:
  name: decode_dispatch

sources:
  - files:
      - hw/dispatch_pkg.sv
      - hw/operand_if.sv
      - hw/decoded_if.sv
      - hw/inst_decoder.sv
      - hw/operand_resolver.sv
      - hw/issue_unit.sv
      - hw/decode_dispatch.sv
  - target: test
    files:
      - tb/decode_dispatch_props.sv
      - tb/tb_decode_dispatch.sv

// File: hw/decode_dispatch.sv
module decode_dispatch (
    input  logic                     clk,
    input  logic                     rst,
    // fetch side
    input  dispatch_pkg::inst_t      inst_in,
    input  logic                     inst_enable,
    input  dispatch_pkg::addr_t      inst_pc,
    output dispatch_pkg::addr_t      pc_offset,
    // register file
    output dispatch_pkg::reg_name_t  reg_name1,
    output dispatch_pkg::reg_name_t  reg_name2,
    input  dispatch_pkg::lock_t      reg_lock1,
    input  dispatch_pkg::lock_t      reg_lock2,
    input  dispatch_pkg::data_t      reg_data1,
    input  dispatch_pkg::data_t      reg_data2,
    output logic                     reg_write,
    output dispatch_pkg::reg_name_t  reg_rd,
    output dispatch_pkg::lock_t      reg_lock,
    // reorder buffer
    input  dispatch_pkg::lock_t      rob_rd_lock,
    output logic                     rob_check_rs1,
    output logic                     rob_check_rs2,
    output dispatch_pkg::rob_entry_t rob_value_entry1,
    output dispatch_pkg::rob_entry_t rob_value_entry2,
    input  logic                     rob_value_enable1,
    input  logic                     rob_value_enable2,
    input  dispatch_pkg::data_t      rob_value1,
    input  dispatch_pkg::data_t      rob_value2,
    output logic                     rob_write,
    output dispatch_pkg::rob_kind_e  rob_kind,
    output dispatch_pkg::addr_t      rob_dest,
    output dispatch_pkg::data_t      rob_value,
    output logic                     rob_ready,
    // alu station
    output logic                     alu_write,
    output dispatch_pkg::simp_op_e   alu_op,
    output dispatch_pkg::lock_t      alu_lock1,
    output dispatch_pkg::lock_t      alu_lock2,
    output dispatch_pkg::data_t      alu_data1,
    output dispatch_pkg::data_t      alu_data2,
    output dispatch_pkg::lock_t      alu_dest,
    // branch station and predictor
    output logic                     bra_write,
    output dispatch_pkg::simp_op_e   bra_op,
    output dispatch_pkg::lock_t      bra_lock1,
    output dispatch_pkg::lock_t      bra_lock2,
    output dispatch_pkg::data_t      bra_data1,
    output dispatch_pkg::data_t      bra_data2,
    output dispatch_pkg::lock_t      bra_dest,
    output logic                     bra_predicted,
    input  logic                     branch_prediction
);
    import dispatch_pkg::*;

    reg_name_t rs1;
    reg_name_t rs2;

    decoded_if dec_bus ();
    operand_if opnd_bus ();

    inst_decoder u_decoder (
        .inst_in (inst_in),
        .dec     (dec_bus.decoder),
        .rs1     (rs1),
        .rs2     (rs2)
    );

    operand_resolver u_resolver (
        .rs1               (rs1),
        .rs2               (rs2),
        .reg_lock1         (reg_lock1),
        .reg_lock2         (reg_lock2),
        .reg_data1         (reg_data1),
        .reg_data2         (reg_data2),
        .rob_check_rs1     (rob_check_rs1),
        .rob_check_rs2     (rob_check_rs2),
        .rob_value_entry1  (rob_value_entry1),
        .rob_value_entry2  (rob_value_entry2),
        .rob_value_enable1 (rob_value_enable1),
        .rob_value_enable2 (rob_value_enable2),
        .rob_value1        (rob_value1),
        .rob_value2        (rob_value2),
        .reg_name1         (reg_name1),
        .reg_name2         (reg_name2),
        .opnd              (opnd_bus.resolver)
    );

    issue_unit u_issue (
        .clk               (clk),
        .rst               (rst),
        .inst_enable       (inst_enable),
        .inst_pc           (inst_pc),
        .rob_rd_lock       (rob_rd_lock),
        .branch_prediction (branch_prediction),
        .dec               (dec_bus.issue),
        .opnd              (opnd_bus.issue),
        .pc_offset         (pc_offset),
        .alu_write         (alu_write),
        .alu_op            (alu_op),
        .alu_lock1         (alu_lock1),
        .alu_lock2         (alu_lock2),
        .alu_data1         (alu_data1),
        .alu_data2         (alu_data2),
        .alu_dest          (alu_dest),
        .bra_write         (bra_write),
        .bra_op            (bra_op),
        .bra_lock1         (bra_lock1),
        .bra_lock2         (bra_lock2),
        .bra_data1         (bra_data1),
        .bra_data2         (bra_data2),
        .bra_dest          (bra_dest),
        .bra_predicted     (bra_predicted),
        .reg_write         (reg_write),
        .reg_rd            (reg_rd),
        .reg_lock          (reg_lock),
        .rob_write         (rob_write),
        .rob_kind          (rob_kind),
        .rob_dest          (rob_dest),
        .rob_value         (rob_value),
        .rob_ready         (rob_ready)
    );

endmodule

// File: hw/decoded_if.sv
interface decoded_if;
    import dispatch_pkg::*;

    simp_op_e  op;
    reg_name_t rd;
    logic      rs2_used;
    data_t     imm_i;
    addr_t     imm_b;
    addr_t     imm_j;

    modport decoder (
        output op,
        output rd,
        output rs2_used,
        output imm_i, imm_b, imm_j
    );

    modport issue (
        input op,
        input rd,
        input rs2_used,
        input imm_i, imm_b, imm_j
    );

endinterface

// File: hw/dispatch_pkg.sv
package dispatch_pkg;

    ///////////////////////////////
    // widths
    ///////////////////////////////
    localparam int INST_W      = 32;
    localparam int DATA_W      = 32;
    localparam int ADDR_W      = 32;
    localparam int REG_NAME_W  = 5;
    localparam int ROB_ENTRY_W = 4;
    localparam int LOCK_W      = 5;

    typedef logic [INST_W-1:0]      inst_t;
    typedef logic [DATA_W-1:0]      data_t;
    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [REG_NAME_W-1:0]  reg_name_t;
    typedef logic [ROB_ENTRY_W-1:0] rob_entry_t;

    // nonzero tag = busy, low bits name the rob slot
    typedef logic [LOCK_W-1:0]      lock_t;

    localparam lock_t NO_LOCK    = '0;
    localparam addr_t INST_BYTES = 32'd4;

    ///////////////////////////////
    // encodings
    ///////////////////////////////
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct7 of the base op and of SUB/SRA
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR,
        OP_OR, OP_AND, OP_SLL, OP_SRL, OP_SRA,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL
    } simp_op_e;

    typedef enum logic {
        ROB_NORMAL,
        ROB_BRANCH
    } rob_kind_e;

endpackage

// File: hw/inst_decoder.sv
module inst_decoder (
    input  dispatch_pkg::inst_t     inst_in,
    decoded_if.decoder              dec,
    output dispatch_pkg::reg_name_t rs1,
    output dispatch_pkg::reg_name_t rs2
);
    import dispatch_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    simp_op_e   base_op;

    // funct3 to op, shared by OP and OP-IMM
    function automatic simp_op_e base_alu_op(input logic [2:0] f3);
        case (f3)
            3'b000:  return OP_ADD;
            3'b001:  return OP_SLL;
            3'b010:  return OP_SLT;
            3'b011:  return OP_SLTU;
            3'b100:  return OP_XOR;
            3'b101:  return OP_SRL;
            3'b110:  return OP_OR;
            default: return OP_AND;
        endcase
    endfunction

    assign opcode = inst_in[6:0];
    assign funct3 = inst_in[14:12];
    assign funct7 = inst_in[31:25];

    assign dec.rd = inst_in[11:7];
    assign rs1    = inst_in[19:15];
    assign rs2    = inst_in[24:20];

    assign dec.rs2_used = (opcode == OPC_OP) || (opcode == OPC_BRANCH);

    ///////////////////////////////
    // immediates
    ///////////////////////////////
    assign dec.imm_i = {{20{inst_in[31]}}, inst_in[31:20]};
    assign dec.imm_b = {{19{inst_in[31]}}, inst_in[31], inst_in[7],
                        inst_in[30:25], inst_in[11:8], 1'b0};
    assign dec.imm_j = {{11{inst_in[31]}}, inst_in[31], inst_in[19:12],
                        inst_in[20], inst_in[30:21], 1'b0};

    assign base_op = base_alu_op(funct3);

    ///////////////////////////////
    // operation lookup
    ///////////////////////////////
    always_comb begin
        dec.op = OP_NOP;
        case (opcode)
            OPC_OP_IMM: begin
                // shifts carry funct7 in the immediate
                if (funct3 != 3'b001 && funct3 != 3'b101) begin
                    dec.op = base_op;
                end else if (funct7 == FUNCT7_BASE) begin
                    dec.op = base_op;
                end else if (funct7 == FUNCT7_ALT && funct3 == 3'b101) begin
                    dec.op = OP_SRA;
                end
            end
            OPC_OP: begin
                if (funct7 == FUNCT7_BASE) begin
                    dec.op = base_op;
                end else if (funct7 == FUNCT7_ALT) begin
                    if (funct3 == 3'b000) begin
                        dec.op = OP_SUB;
                    end else if (funct3 == 3'b101) begin
                        dec.op = OP_SRA;
                    end
                end
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  dec.op = OP_BEQ;
                    3'b001:  dec.op = OP_BNE;
                    3'b100:  dec.op = OP_BLT;
                    3'b101:  dec.op = OP_BGE;
                    3'b110:  dec.op = OP_BLTU;
                    3'b111:  dec.op = OP_BGEU;
                    default: dec.op = OP_NOP;
                endcase
            end
            OPC_JAL: dec.op = OP_JAL;
            default: dec.op = OP_NOP;
        endcase
    end

endmodule

// File: hw/issue_unit.sv
module issue_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inst_enable,
    input  dispatch_pkg::addr_t     inst_pc,
    input  dispatch_pkg::lock_t     rob_rd_lock,
    input  logic                    branch_prediction,
    decoded_if.issue                dec,
    operand_if.issue                opnd,
    output dispatch_pkg::addr_t     pc_offset,
    output logic                    alu_write,
    output dispatch_pkg::simp_op_e  alu_op,
    output dispatch_pkg::lock_t     alu_lock1,
    output dispatch_pkg::lock_t     alu_lock2,
    output dispatch_pkg::data_t     alu_data1,
    output dispatch_pkg::data_t     alu_data2,
    output dispatch_pkg::lock_t     alu_dest,
    output logic                    bra_write,
    output dispatch_pkg::simp_op_e  bra_op,
    output dispatch_pkg::lock_t     bra_lock1,
    output dispatch_pkg::lock_t     bra_lock2,
    output dispatch_pkg::data_t     bra_data1,
    output dispatch_pkg::data_t     bra_data2,
    output dispatch_pkg::lock_t     bra_dest,
    output logic                    bra_predicted,
    output logic                    reg_write,
    output dispatch_pkg::reg_name_t reg_rd,
    output dispatch_pkg::lock_t     reg_lock,
    output logic                    rob_write,
    output dispatch_pkg::rob_kind_e rob_kind,
    output dispatch_pkg::addr_t     rob_dest,
    output dispatch_pkg::data_t     rob_value,
    output logic                    rob_ready
);
    import dispatch_pkg::*;

    lock_t    op2_lock;
    data_t    op2_data;
    logic     is_alu;
    logic     is_branch;
    logic     is_jal;
    logic     cmp_true;
    logic     resolved;
    logic     taken;
    addr_t    not_taken_pc;

    // shared operand record for alu and branch station
    simp_op_e rec_op;
    lock_t    rec_lock1;
    lock_t    rec_lock2;
    data_t    rec_data1;
    data_t    rec_data2;
    lock_t    rec_dest;

    // OP-IMM takes the I immediate as operand 2
    assign op2_lock = dec.rs2_used ? opnd.lock2 : NO_LOCK;
    assign op2_data = dec.rs2_used ? opnd.data2 : dec.imm_i;

    always_comb begin
        is_alu    = 1'b0;
        is_branch = 1'b1;
        cmp_true  = 1'b0;
        case (dec.op)
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR,
            OP_OR, OP_AND, OP_SLL, OP_SRL, OP_SRA: begin
                is_alu    = 1'b1;
                is_branch = 1'b0;
            end
            OP_BEQ:  cmp_true = (opnd.data1 == op2_data);
            OP_BNE:  cmp_true = (opnd.data1 != op2_data);
            OP_BLT:  cmp_true = ($signed(opnd.data1) < $signed(op2_data));
            OP_BGE:  cmp_true = ($signed(opnd.data1) >= $signed(op2_data));
            OP_BLTU: cmp_true = (opnd.data1 < op2_data);
            OP_BGEU: cmp_true = (opnd.data1 >= op2_data);
            default: is_branch = 1'b0;
        endcase
    end

    assign is_jal   = (dec.op == OP_JAL);
    assign resolved = (opnd.lock1 == NO_LOCK) && (op2_lock == NO_LOCK);
    assign taken    = is_branch && (resolved ? cmp_true : branch_prediction);

    // rob keeps the other path for recovery
    assign not_taken_pc = taken ? inst_pc + INST_BYTES : inst_pc + dec.imm_b;

    assign pc_offset = !inst_enable ? INST_BYTES :
                       is_jal       ? dec.imm_j  :
                       taken        ? dec.imm_b  : INST_BYTES;

    ///////////////////////////////
    // issue records
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_write <= 1'b0;
            bra_write <= 1'b0;
            reg_write <= 1'b0;
            rob_write <= 1'b0;
        end else begin
            alu_write <= inst_enable && is_alu;
            bra_write <= inst_enable && is_branch && !resolved;
            reg_write <= inst_enable && (is_alu || is_jal);
            rob_write <= inst_enable && (is_alu || is_jal || is_branch);
        end
    end

    always_ff @(posedge clk) begin
        if (inst_enable) begin
            rec_op        <= dec.op;
            rec_lock1     <= opnd.lock1;
            rec_data1     <= opnd.data1;
            rec_lock2     <= op2_lock;
            rec_data2     <= op2_data;
            rec_dest      <= rob_rd_lock;
            bra_predicted <= branch_prediction;
            reg_rd        <= dec.rd;
            reg_lock      <= rob_rd_lock;
            rob_kind      <= is_branch ? ROB_BRANCH : ROB_NORMAL;
            rob_dest      <= is_branch ? not_taken_pc : addr_t'(dec.rd);
            // jal link, or taken bit (guess when unresolved)
            rob_value     <= is_jal ? data_t'(inst_pc + INST_BYTES) : data_t'(taken);
            rob_ready     <= is_jal || (is_branch && resolved);
        end
    end

    assign alu_op    = rec_op;
    assign alu_lock1 = rec_lock1;
    assign alu_lock2 = rec_lock2;
    assign alu_data1 = rec_data1;
    assign alu_data2 = rec_data2;
    assign alu_dest  = rec_dest;

    assign bra_op    = rec_op;
    assign bra_lock1 = rec_lock1;
    assign bra_lock2 = rec_lock2;
    assign bra_data1 = rec_data1;
    assign bra_data2 = rec_data2;
    assign bra_dest  = rec_dest;

endmodule

// File: hw/operand_if.sv
interface operand_if;
    import dispatch_pkg::*;

    // lock is NO_LOCK when data is valid, else tag with zero data
    lock_t lock1;
    data_t data1;
    lock_t lock2;
    data_t data2;

    modport resolver (
        output lock1, data1,
        output lock2, data2
    );

    modport issue (
        input lock1, data1,
        input lock2, data2
    );

endinterface

// File: hw/operand_resolver.sv
module operand_resolver (
    input  dispatch_pkg::reg_name_t  rs1,
    input  dispatch_pkg::reg_name_t  rs2,
    input  dispatch_pkg::lock_t      reg_lock1,
    input  dispatch_pkg::lock_t      reg_lock2,
    input  dispatch_pkg::data_t      reg_data1,
    input  dispatch_pkg::data_t      reg_data2,
    output logic                     rob_check_rs1,
    output logic                     rob_check_rs2,
    output dispatch_pkg::rob_entry_t rob_value_entry1,
    output dispatch_pkg::rob_entry_t rob_value_entry2,
    input  logic                     rob_value_enable1,
    input  logic                     rob_value_enable2,
    input  dispatch_pkg::data_t      rob_value1,
    input  dispatch_pkg::data_t      rob_value2,
    output dispatch_pkg::reg_name_t  reg_name1,
    output dispatch_pkg::reg_name_t  reg_name2,
    operand_if.resolver              opnd
);
    import dispatch_pkg::*;

    // busy reg stays locked unless the rob already holds its value
    function automatic lock_t pick_lock(input lock_t lock, input logic rob_ready);
        return (lock == NO_LOCK || rob_ready) ? NO_LOCK : lock;
    endfunction

    function automatic data_t pick_data(input lock_t lock, input logic rob_ready,
                                        input data_t reg_val, input data_t rob_val);
        if (lock == NO_LOCK) begin
            return reg_val;
        end
        return rob_ready ? rob_val : '0;
    endfunction

    assign reg_name1 = rs1;
    assign reg_name2 = rs2;

    // rob query by tag
    assign rob_check_rs1    = (reg_lock1 != NO_LOCK);
    assign rob_check_rs2    = (reg_lock2 != NO_LOCK);
    assign rob_value_entry1 = reg_lock1[ROB_ENTRY_W-1:0];
    assign rob_value_entry2 = reg_lock2[ROB_ENTRY_W-1:0];

    assign opnd.lock1 = pick_lock(reg_lock1, rob_value_enable1);
    assign opnd.data1 = pick_data(reg_lock1, rob_value_enable1, reg_data1, rob_value1);
    assign opnd.lock2 = pick_lock(reg_lock2, rob_value_enable2);
    assign opnd.data2 = pick_data(reg_lock2, rob_value_enable2, reg_data2, rob_value2);

endmodule

// File: sim.f
hw/dispatch_pkg.sv
hw/operand_if.sv
hw/decoded_if.sv
hw/inst_decoder.sv
hw/operand_resolver.sv
hw/issue_unit.sv
hw/decode_dispatch.sv
tb/decode_dispatch_props.sv
tb/tb_decode_dispatch.sv

// File: tb/decode_dispatch_props.sv
module decode_dispatch_props (
    input logic clk,
    input logic rst,
    input logic inst_enable,
    input logic alu_write,
    input logic bra_write,
    input logic reg_write,
    input logic rob_write
);
    timeunit 1ns;
    timeprecision 100ps;

    int   assert_failures = 0;
    logic any_write;

    assign any_write = alu_write || bra_write || reg_write || rob_write;

    // an instruction goes to at most one station
    one_station: assert property (@(posedge clk) disable iff (rst)
        !(alu_write && bra_write))
    else begin
        assert_failures++;
        $error("alu_write and bra_write high in the same cycle");
    end

    lock_needs_rob: assert property (@(posedge clk) disable iff (rst)
        reg_write |-> rob_write)
    else begin
        assert_failures++;
        $error("reg_write without rob_write");
    end

    // strobes follow reset or an idle edge
    quiet_after_gap: assert property (@(posedge clk) disable iff (rst)
        ($past(rst) || !$past(inst_enable)) |-> !any_write)
    else begin
        assert_failures++;
        $error("write strobe after reset or idle cycle");
    end

endmodule

bind decode_dispatch decode_dispatch_props u_props (
    .clk         (clk),
    .rst         (rst),
    .inst_enable (inst_enable),
    .alu_write   (alu_write),
    .bra_write   (bra_write),
    .reg_write   (reg_write),
    .rob_write   (rob_write)
);

// File: tb/dispatch_cases.txt
# stim (hex): name inst pc en lock1 data1 lock2 data2 rob_en1 rob_val1 rob_en2 rob_val2 pred rd_lock
# expect (hex): pc_off alu bra reg rob alu_op bra_op pred ready rob_dest rob_value lk1 d1 lk2 d2
add_regs 002081b3 00001000 1 00 00000011 00 00000022 0 00000000 0 00000000 0 05
    00000004 1 0 1 1 01 01 0 0 00000003 00000000 00 00000011 00 00000022
addi_neg ffd20293 00001000 1 00 00000100 07 0000dead 0 00000000 0 00000000 0 06
    00000004 1 0 1 1 01 01 0 0 00000005 00000000 00 00000100 00 fffffffd
srai_shift 40445493 00001000 1 00 80000000 00 00000000 0 00000000 0 00000000 0 0a
    00000004 1 0 1 1 0a 0a 0 0 00000009 00000000 00 80000000 00 00000404
sub_fwd 405303b3 00001000 1 13 00000099 0a 00000055 1 00001234 0 00000777 0 08
    00000004 1 0 1 1 02 02 0 0 00000007 00000000 00 00001234 0a 00000000
beq_taken 00208863 00001000 1 00 00000042 00 00000042 0 00000000 0 00000000 0 00
    00000010 0 0 0 1 0b 0b 0 1 00001004 00000001 00 00000042 00 00000042
bne_not 00209863 00001000 1 00 00000042 00 00000042 0 00000000 0 00000000 1 00
    00000004 0 0 0 1 0c 0c 0 1 00001010 00000000 00 00000042 00 00000042
blt_signed 0020c863 00001000 1 00 fffffff0 00 00000005 0 00000000 0 00000000 0 00
    00000010 0 0 0 1 0d 0d 0 1 00001004 00000001 00 fffffff0 00 00000005
bge_signed 0020d863 00001000 1 00 fffffff0 00 00000005 0 00000000 0 00000000 0 00
    00000004 0 0 0 1 0e 0e 0 1 00001010 00000000 00 fffffff0 00 00000005
bltu_unsigned fe20ece3 00001000 1 00 fffffff0 00 00000005 0 00000000 0 00000000 0 00
    00000004 0 0 0 1 0f 0f 0 1 00000ff8 00000000 00 fffffff0 00 00000005
bgeu_unsigned fe20fce3 00001000 1 00 fffffff0 00 00000005 0 00000000 0 00000000 0 00
    fffffff8 0 0 0 1 10 10 0 1 00001004 00000001 00 fffffff0 00 00000005
br_pending 00208863 00001000 1 00 00000042 0c 00000042 0 00000000 0 00000000 1 00
    00000010 0 1 0 1 0b 0b 1 0 00001004 00000001 00 00000042 0c 00000000
jal_link 100000ef 00002000 1 00 00000000 00 00000000 0 00000000 0 00000000 0 09
    00000100 0 0 1 1 11 11 0 1 00000001 00002004 00 00000000 00 00000000
load_nop 0000a283 00001000 1 00 00000000 00 00000000 0 00000000 0 00000000 0 00
    00000004 0 0 0 0 00 00 0 0 00000000 00000000 00 00000000 00 00000000
idle_jal 100000ef 00002000 0 00 00000000 00 00000000 0 00000000 0 00000000 0 00
    00000004 0 0 0 0 00 00 0 0 00000000 00000000 00 00000000 00 00000000

// File: tb/tb_decode_dispatch.sv
module tb_decode_dispatch;
    timeunit 1ns;
    timeprecision 100ps;

    import dispatch_pkg::*;

    typedef struct {
        string      name;
        inst_t      inst;
        addr_t      pc;
        logic       en;
        lock_t      lock1;
        data_t      data1;
        lock_t      lock2;
        data_t      data2;
        logic       rven1;
        data_t      rval1;
        logic       rven2;
        data_t      rval2;
        logic       pred;
        lock_t      rd_lock;
        addr_t      x_pc_offset;
        logic       x_alu_w;
        logic       x_bra_w;
        logic       x_reg_w;
        logic       x_rob_w;
        logic [4:0] x_alu_op;
        logic [4:0] x_bra_op;
        logic       x_bra_pred;
        logic       x_rob_ready;
        addr_t      x_rob_dest;
        data_t      x_rob_value;
        lock_t      x_lock1;
        data_t      x_data1;
        lock_t      x_lock2;
        data_t      x_data2;
    } test_case_t;

    logic       clk;
    logic       rst;
    inst_t      inst_in;
    logic       inst_enable;
    addr_t      inst_pc;
    addr_t      pc_offset;
    reg_name_t  reg_name1, reg_name2;
    lock_t      reg_lock1, reg_lock2;
    data_t      reg_data1, reg_data2;
    logic       reg_write;
    reg_name_t  reg_rd;
    lock_t      reg_lock;
    lock_t      rob_rd_lock;
    logic       rob_check_rs1, rob_check_rs2;
    rob_entry_t rob_value_entry1, rob_value_entry2;
    logic       rob_value_enable1, rob_value_enable2;
    data_t      rob_value1, rob_value2;
    logic       rob_write;
    rob_kind_e  rob_kind;
    addr_t      rob_dest;
    data_t      rob_value;
    logic       rob_ready;
    logic       alu_write;
    simp_op_e   alu_op;
    lock_t      alu_lock1, alu_lock2;
    data_t      alu_data1, alu_data2;
    lock_t      alu_dest;
    logic       bra_write;
    simp_op_e   bra_op;
    lock_t      bra_lock1, bra_lock2;
    data_t      bra_data1, bra_data2;
    lock_t      bra_dest;
    logic       bra_predicted;
    logic       branch_prediction;

    test_case_t cases[$];
    logic       load_ok = 1'b1;
    int         case_errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         cycles = 0;
    int         cycle_limit = 30;

    decode_dispatch dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic check_flag(input string sig, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %b got %b", $time, sig, exp, act);
            case_errors++;
        end
    endtask

    task automatic check_op(input string sig, input simp_op_e exp, input simp_op_e act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %s(%0h) got %s(%0h)", $time, sig,
                     exp.name(), exp, act.name(), act);
            case_errors++;
        end
    endtask

    task automatic check_kind(input string sig, input rob_kind_e exp, input rob_kind_e act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %s got %s", $time, sig,
                     exp.name(), act.name());
            case_errors++;
        end
    endtask

    task automatic check_addr(input string sig, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, sig, exp, act);
            case_errors++;
        end
    endtask

    task automatic check_data(input string sig, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, sig, exp, act);
            case_errors++;
        end
    endtask

    task automatic check_lock(input string sig, input lock_t exp, input lock_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, sig, exp, act);
            case_errors++;
        end
    endtask

    task automatic check_entry(input string sig, input rob_entry_t exp, input rob_entry_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, sig, exp, act);
            case_errors++;
        end
    endtask

    task automatic check_reg(input string sig, input reg_name_t exp, input reg_name_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, sig, exp, act);
            case_errors++;
        end
    endtask

    // branch ops take a branch-kind rob entry
    function automatic rob_kind_e kind_of_op(input simp_op_e op);
        case (op)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: return ROB_BRANCH;
            default: return ROB_NORMAL;
        endcase
    endfunction

    task automatic finish_test(input string name);
        tests_run++;
        if (case_errors != 0) begin
            tests_failed++;
        end
        $display("test %0s %s", name, (case_errors == 0) ? "passed" : "failed");
        case_errors = 0;
    endtask

    //////////////////////////////
    // case file
    //////////////////////////////
    task automatic load_cases();
        int         fd;
        int         n;
        string      line;
        test_case_t c;
        logic       have_stim;
        fd = $fopen("tb/dispatch_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/dispatch_cases.txt");
            load_ok = 1'b0;
            return;
        end
        have_stim = 1'b0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if (!have_stim) begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            c.name, c.inst, c.pc, c.en, c.lock1, c.data1, c.lock2,
                            c.data2, c.rven1, c.rval1, c.rven2, c.rval2, c.pred,
                            c.rd_lock);
                have_stim = (n == 14);
            end else begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            c.x_pc_offset, c.x_alu_w, c.x_bra_w, c.x_reg_w, c.x_rob_w,
                            c.x_alu_op, c.x_bra_op, c.x_bra_pred, c.x_rob_ready,
                            c.x_rob_dest, c.x_rob_value, c.x_lock1, c.x_data1,
                            c.x_lock2, c.x_data2);
                if (n == 15) begin
                    cases.push_back(c);
                end
                have_stim = 1'b0;
            end
            if (n != 14 && n != 15) begin
                $display("malformed line in case file: %0s", line);
                load_ok = 1'b0;
            end
        end
        $fclose(fd);
        if (have_stim || cases.size() == 0) begin
            $display("case file is empty or ends in the middle of a case");
            load_ok = 1'b0;
        end
    endtask

    task automatic check_reset();
        check_flag("alu_write", 1'b0, alu_write);
        check_flag("bra_write", 1'b0, bra_write);
        check_flag("reg_write", 1'b0, reg_write);
        check_flag("rob_write", 1'b0, rob_write);
        check_addr("pc_offset", 32'd4, pc_offset);
        finish_test("reset");
    endtask

    task automatic run_case(input test_case_t c);
        @(posedge clk);
        #1;
        inst_in           = c.inst;
        inst_pc           = c.pc;
        inst_enable       = c.en;
        reg_lock1         = c.lock1;
        reg_data1         = c.data1;
        reg_lock2         = c.lock2;
        reg_data2         = c.data2;
        rob_value_enable1 = c.rven1;
        rob_value1        = c.rval1;
        rob_value_enable2 = c.rven2;
        rob_value2        = c.rval2;
        branch_prediction = c.pred;
        rob_rd_lock       = c.rd_lock;
        #3;
        // next pc is combinational
        check_addr("pc_offset", c.x_pc_offset, pc_offset);
        // register file and rob queries
        check_reg("reg_name1", c.inst[19:15], reg_name1);
        check_reg("reg_name2", c.inst[24:20], reg_name2);
        check_flag("rob_check_rs1", c.lock1 != NO_LOCK, rob_check_rs1);
        check_flag("rob_check_rs2", c.lock2 != NO_LOCK, rob_check_rs2);
        if (c.lock1 != NO_LOCK) begin
            check_entry("rob_value_entry1", c.lock1[ROB_ENTRY_W-1:0], rob_value_entry1);
        end
        if (c.lock2 != NO_LOCK) begin
            check_entry("rob_value_entry2", c.lock2[ROB_ENTRY_W-1:0], rob_value_entry2);
        end
        @(posedge clk);
        #1;
        inst_enable = 1'b0;
        check_flag("alu_write", c.x_alu_w, alu_write);
        check_flag("bra_write", c.x_bra_w, bra_write);
        check_flag("reg_write", c.x_reg_w, reg_write);
        check_flag("rob_write", c.x_rob_w, rob_write);
        if (c.x_alu_w) begin
            check_op("alu_op", simp_op_e'(c.x_alu_op), alu_op);
            check_lock("alu_lock1", c.x_lock1, alu_lock1);
            check_data("alu_data1", c.x_data1, alu_data1);
            check_lock("alu_lock2", c.x_lock2, alu_lock2);
            check_data("alu_data2", c.x_data2, alu_data2);
            check_lock("alu_dest", c.rd_lock, alu_dest);
        end
        if (c.x_bra_w) begin
            check_op("bra_op", simp_op_e'(c.x_bra_op), bra_op);
            check_flag("bra_predicted", c.x_bra_pred, bra_predicted);
            check_lock("bra_lock1", c.x_lock1, bra_lock1);
            check_data("bra_data1", c.x_data1, bra_data1);
            check_lock("bra_lock2", c.x_lock2, bra_lock2);
            check_data("bra_data2", c.x_data2, bra_data2);
            check_lock("bra_dest", c.rd_lock, bra_dest);
        end
        if (c.x_reg_w) begin
            check_reg("reg_rd", c.inst[11:7], reg_rd);
            check_lock("reg_lock", c.rd_lock, reg_lock);
        end
        if (c.x_rob_w) begin
            check_kind("rob_kind", kind_of_op(simp_op_e'(c.x_bra_op)), rob_kind);
            check_flag("rob_ready", c.x_rob_ready, rob_ready);
            check_addr("rob_dest", c.x_rob_dest, rob_dest);
            check_data("rob_value", c.x_rob_value, rob_value);
        end
        finish_test(c.name);
    endtask

    initial begin
        rst               = 1'b1;
        inst_in           = '0;
        inst_enable       = 1'b0;
        inst_pc           = '0;
        reg_lock1         = '0;
        reg_lock2         = '0;
        reg_data1         = '0;
        reg_data2         = '0;
        rob_rd_lock       = '0;
        rob_value_enable1 = 1'b0;
        rob_value_enable2 = 1'b0;
        rob_value1        = '0;
        rob_value2        = '0;
        branch_prediction = 1'b0;
        load_cases();
        cycle_limit = 10 + 3 * cases.size() + 20;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        if (load_ok) begin
            check_reset();
            foreach (cases[i]) begin
                run_case(cases[i]);
            end
        end
        @(posedge clk);
        $display("tests: %0d run, %0d passed, %0d failed, %0d assertion failures",
                 tests_run, tests_run - tests_failed, tests_failed,
                 dut.u_props.assert_failures);
        if (load_ok && tests_failed == 0 && dut.u_props.assert_failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
